// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int WORD_W   = 32;
	localparam int REG_CNT  = 16;
	localparam int REG_W    = 4;
	localparam int OPCODE_W = 5;
	localparam int CONST_W  = 19;

	// opcode map of the kept instructions, encodings unchanged
	typedef enum logic [OPCODE_W-1:0] {
		OP_LD   = 5'b00000,
		OP_LDI  = 5'b00001,
		OP_ST   = 5'b00010,
		OP_ADD  = 5'b00011,
		OP_SUB  = 5'b00100,
		OP_SHR  = 5'b00101,
		OP_SHL  = 5'b00110,
		OP_AND  = 5'b01001,
		OP_OR   = 5'b01010,
		OP_ANDI = 5'b01100,
		OP_ORI  = 5'b01101,
		OP_NEG  = 5'b10000,
		OP_NOT  = 5'b10001,
		OP_BR   = 5'b10010,
		OP_NOP  = 5'b11001,
		OP_HALT = 5'b11010
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SHR, ALU_SHL, ALU_NEG, ALU_NOT
	} alu_op_e;

	// the register operand of the alu b input is rc, or rb for the unary ops
	typedef enum logic [1:0] {B_CONST, B_RC, B_RB} b_sel_e;

	////////////////////////////////////////////////////////////////////////////
	// instruction formats
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcode_e                                  opcode;
		logic [REG_W-1:0]                         ra;
		logic [REG_W-1:0]                         rb;
		logic [REG_W-1:0]                         rc;
		logic [WORD_W-OPCODE_W-3*REG_W-1:0]       unused;
	} instr_r_t;

	typedef struct packed {
		opcode_e              opcode;
		logic [REG_W-1:0]     ra;
		logic [REG_W-1:0]     rb;
		logic [CONST_W-1:0]   imm;
	} instr_i_t;

	typedef struct packed {
		opcode_e              opcode;
		logic [REG_W-1:0]     ra;
		logic [1:0]           unused;
		logic [1:0]           c2;     // 0 zero, 1 nonzero, 2 positive, 3 negative
		logic [CONST_W-1:0]   imm;
	} instr_b_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
		instr_b_t b;
	} instr_u;

	typedef struct packed {
		logic     ir_load;
		logic     mar_load;
		logic     mdr_load_mem;
		logic     mdr_load_reg;     // MDR takes ra for a store
		logic     y_load;
		logic     z_load;
		b_sel_e   b_sel;
		alu_op_e  alu_op;
		logic     reg_write;
		logic     wr_sel;           // 0 writes Z, 1 writes MDR
		logic     base_mode;        // r0 reads as zero on the rb port
		logic     mar_from_pc;      // pc feeds MAR and Y instead of Z and rb
	} ctrl_t;

	typedef struct packed {
		logic                 req;
		logic                 we;
		logic [WORD_W-1:0]    addr;
		logic [WORD_W-1:0]    wdata;
	} mem_req_t;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps
module alu import cpu_pkg::*; (
	input  alu_op_e           op,
	input  logic [WORD_W-1:0] a,
	input  logic [WORD_W-1:0] b,
	output logic [WORD_W-1:0] result
);

	localparam int SHAMT_W = $clog2(WORD_W);

	logic [SHAMT_W-1:0] shamt;

	assign shamt = b[SHAMT_W-1:0]; // only the low bits of rc count

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;   // wraps modulo 2^32
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SHR: result = a >> shamt; // logical, zeros shift in
			ALU_SHL: result = a << shamt;
			// the unary ops look at b alone
			ALU_NEG: result = -b;
			ALU_NOT: result = ~b;
			default: result = '0;
		endcase
	end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps
module register_file import cpu_pkg::*; (
	input  logic              clk,
	input  logic              reset_n,
	input  logic [REG_W-1:0]  read_a_idx,
	input  logic [REG_W-1:0]  read_b_idx,
	input  logic [REG_W-1:0]  write_idx,
	input  logic              base_mode,
	input  logic              write_en,
	input  logic [WORD_W-1:0] write_data,
	output logic [WORD_W-1:0] read_a,
	output logic [WORD_W-1:0] read_b
);

	logic [WORD_W-1:0] regs [REG_CNT];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_idx] <= write_data;
		end
	end

	assign read_a = regs[read_a_idx];

	// r0 is a normal register except when it serves as a base
	assign read_b = (base_mode && read_b_idx == '0) ? '0 : regs[read_b_idx];

endmodule

// ==== design/program_counter.sv ====
`timescale 1ns/1ps
module program_counter import cpu_pkg::*; (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              pc_inc,
	input  logic              pc_load,
	input  logic [WORD_W-1:0] target,
	output logic [WORD_W-1:0] pc
);

	logic [WORD_W-1:0] pc_reg;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc_reg <= '0;
		end else if (pc_load) begin
			pc_reg <= target; // a taken branch wins over the fetch increment
		end else if (pc_inc) begin
			pc_reg <= pc_reg + 1'b1; // word addresses so one step per instruction
		end
	end

	assign pc = pc_reg;

endmodule

// ==== design/cpu_control.sv ====
`timescale 1ns/1ps
module cpu_control import cpu_pkg::*; (
	input  logic   clk,
	input  logic   reset_n,
	input  instr_u instr,
	input  logic   cond_true,
	input  logic   mem_ack,
	output ctrl_t  ctrl,
	output logic   pc_inc,
	output logic   pc_load,
	output logic   mem_req_valid,
	output logic   mem_we,
	output logic   halted
);

	typedef enum logic [3:0] {
		S_RESET,
		S_FETCH_ADDR,
		S_FETCH_WAIT,
		S_DECODE,
		S_OPERAND,
		S_RESULT,
		S_WRITE,
		S_MEM_ADDR,
		S_MEM_WAIT,
		S_MEM_RELEASE,
		S_HALTED
	} state_e;

	state_e  state;
	state_e  state_next;
	opcode_e opcode;
	logic    take_branch;
	logic    is_alu_r;
	logic    is_unary;
	logic    is_imm;
	logic    is_ld;
	logic    is_st;
	logic    is_br;

	function automatic alu_op_e alu_of(input opcode_e op);
		case (op)
			OP_SUB:         return ALU_SUB;
			OP_AND, OP_ANDI: return ALU_AND;
			OP_OR, OP_ORI:   return ALU_OR;
			OP_SHR:         return ALU_SHR;
			OP_SHL:         return ALU_SHL;
			OP_NEG:         return ALU_NEG;
			OP_NOT:         return ALU_NOT;
			default:        return ALU_ADD; // add, address and branch target sums
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// opcode classes
	////////////////////////////////////////////////////////////////////////////

	assign opcode   = instr.r.opcode;
	assign is_alu_r = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SHR, OP_SHL};
	assign is_unary = opcode inside {OP_NEG, OP_NOT};
	assign is_imm   = opcode inside {OP_LDI, OP_ANDI, OP_ORI};
	assign is_ld    = (opcode == OP_LD);
	assign is_st    = (opcode == OP_ST);
	assign is_br    = (opcode == OP_BR);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_RESET;
			take_branch <= 1'b0;
		end else begin
			state <= state_next;
			if (state == S_OPERAND && is_br) begin
				take_branch <= cond_true; // ra is tested while Y takes pc
			end
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			S_RESET:      state_next = S_FETCH_ADDR;
			S_FETCH_ADDR: state_next = S_FETCH_WAIT;
			S_FETCH_WAIT: if (mem_ack) state_next = S_DECODE;
			S_DECODE:     if (!mem_ack) state_next = S_OPERAND; // ack must fall first
			S_OPERAND: begin
				if (is_alu_r || is_unary || is_imm || is_ld || is_st || is_br) begin
					state_next = S_RESULT;
				end else if (opcode == OP_HALT) begin
					state_next = S_HALTED;
				end else begin
					state_next = S_FETCH_ADDR; // nop and undefined opcodes do nothing
				end
			end
			S_RESULT:      state_next = (is_ld || is_st) ? S_MEM_ADDR : S_WRITE;
			S_WRITE:       state_next = S_FETCH_ADDR;
			S_MEM_ADDR:    state_next = S_MEM_WAIT;
			S_MEM_WAIT:    if (mem_ack) state_next = S_MEM_RELEASE;
			S_MEM_RELEASE: if (!mem_ack) state_next = S_FETCH_ADDR;
			S_HALTED:      state_next = S_HALTED; // only reset leaves
			default:       state_next = S_RESET;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// control word per step
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		pc_inc = 1'b0;
		pc_load = 1'b0;
		case (state)
			S_FETCH_ADDR: begin
				ctrl.mar_load = 1'b1;
				ctrl.mar_from_pc = 1'b1;
				pc_inc = 1'b1;
			end
			S_FETCH_WAIT: ctrl.mdr_load_mem = mem_ack;
			S_DECODE:     ctrl.ir_load = 1'b1;
			S_OPERAND: begin
				// Y takes rb, the base for memory and immediate forms, or pc for br
				ctrl.y_load = is_alu_r || is_unary || is_imm || is_ld || is_st || is_br;
				ctrl.base_mode = is_imm || is_ld || is_st;
				ctrl.mar_from_pc = is_br;
			end
			S_RESULT: begin
				ctrl.z_load = 1'b1;
				ctrl.alu_op = alu_of(opcode);
				if (is_alu_r) begin
					ctrl.b_sel = B_RC;
				end else if (is_unary) begin
					ctrl.b_sel = B_RB;
				end else begin
					ctrl.b_sel = B_CONST;
				end
			end
			S_WRITE: begin
				ctrl.reg_write = !is_br;
				pc_load = is_br && take_branch;
			end
			S_MEM_ADDR: begin
				ctrl.mar_load = 1'b1; // effective address from Z
				ctrl.mdr_load_reg = is_st;
			end
			S_MEM_WAIT:    ctrl.mdr_load_mem = mem_ack && is_ld;
			S_MEM_RELEASE: begin
				ctrl.reg_write = is_ld;
				ctrl.wr_sel = 1'b1;
			end
			default: ;
		endcase
	end

	assign mem_req_valid = (state == S_FETCH_WAIT) || (state == S_MEM_WAIT);
	assign mem_we = (state == S_MEM_WAIT) && is_st;
	assign halted = (state == S_HALTED);

endmodule

// ==== design/cpu_datapath.sv ====
`timescale 1ns/1ps
module cpu_datapath import cpu_pkg::*; (
	input  logic              clk,
	input  logic              reset_n,
	input  ctrl_t             ctrl,
	input  logic [WORD_W-1:0] pc,
	input  logic [WORD_W-1:0] mem_rdata,
	output instr_u            instr,
	output logic              cond_true,
	output logic [WORD_W-1:0] target,
	output logic [WORD_W-1:0] mem_addr,
	output logic [WORD_W-1:0] mem_wdata
);

	instr_u            ir;
	logic [WORD_W-1:0] mar;
	logic [WORD_W-1:0] mdr;
	logic [WORD_W-1:0] y_reg;
	logic [WORD_W-1:0] z_reg;
	logic [WORD_W-1:0] const_ext;
	logic [WORD_W-1:0] read_a;
	logic [WORD_W-1:0] read_b;
	logic [WORD_W-1:0] alu_b;
	logic [WORD_W-1:0] alu_result;
	logic [WORD_W-1:0] write_data;
	logic [REG_W-1:0]  read_a_idx;

	////////////////////////////////////////////////////////////////////////////
	// operand selection
	////////////////////////////////////////////////////////////////////////////

	assign const_ext = {{(WORD_W-CONST_W){ir.i.imm[CONST_W-1]}}, ir.i.imm};

	// port a carries ra unless the alu wants a register on its b input
	always_comb begin
		case (ctrl.b_sel)
			B_RC:    read_a_idx = ir.r.rc;
			B_RB:    read_a_idx = ir.r.rb;
			default: read_a_idx = ir.r.ra;
		endcase
	end

	assign alu_b = (ctrl.b_sel == B_CONST) ? const_ext : read_a;
	assign write_data = ctrl.wr_sel ? mdr : z_reg;

	always_ff @(posedge clk) begin
		if (ctrl.ir_load) begin
			ir <= mdr; // the fetched word sits in MDR one cycle before IR
		end
		if (ctrl.mar_load) begin
			mar <= ctrl.mar_from_pc ? pc : z_reg;
		end
		if (ctrl.mdr_load_mem) begin
			mdr <= mem_rdata;
		end else if (ctrl.mdr_load_reg) begin
			mdr <= read_a;
		end
		if (ctrl.y_load) begin
			y_reg <= ctrl.mar_from_pc ? pc : read_b;
		end
		if (ctrl.z_load) begin
			z_reg <= alu_result;
		end
	end

	// branch test on ra, c2 picks the condition
	always_comb begin
		case (ir.b.c2)
			2'd0:    cond_true = (read_a == '0);
			2'd1:    cond_true = (read_a != '0);
			2'd2:    cond_true = !read_a[WORD_W-1] && (read_a != '0);
			default: cond_true = read_a[WORD_W-1];
		endcase
	end

	register_file u_register_file (
		.clk        (clk),
		.reset_n    (reset_n),
		.read_a_idx (read_a_idx),
		.read_b_idx (ir.r.rb),
		.write_idx  (ir.r.ra),
		.base_mode  (ctrl.base_mode),
		.write_en   (ctrl.reg_write),
		.write_data (write_data),
		.read_a     (read_a),
		.read_b     (read_b)
	);

	alu u_alu (
		.op     (ctrl.alu_op),
		.a      (y_reg),
		.b      (alu_b),
		.result (alu_result)
	);

	assign instr = ir;
	assign target = z_reg; // pc+1 plus the constant after the br sum
	assign mem_addr = mar;
	assign mem_wdata = mdr;

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
module cpu_top import cpu_pkg::*; (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              mem_ack,
	input  logic [WORD_W-1:0] mem_rdata,
	output mem_req_t          mem_req,
	output logic              halted
);

	ctrl_t             ctrl;
	instr_u            instr;
	logic              cond_true;
	logic              pc_inc;
	logic              pc_load;
	logic              req_valid;
	logic              req_we;
	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] target;
	logic [WORD_W-1:0] mem_addr;
	logic [WORD_W-1:0] mem_wdata;

	cpu_control u_cpu_control (
		.clk           (clk),
		.reset_n       (reset_n),
		.instr         (instr),
		.cond_true     (cond_true),
		.mem_ack       (mem_ack),
		.ctrl          (ctrl),
		.pc_inc        (pc_inc),
		.pc_load       (pc_load),
		.mem_req_valid (req_valid),
		.mem_we        (req_we),
		.halted        (halted)
	);

	program_counter u_program_counter (
		.clk     (clk),
		.reset_n (reset_n),
		.pc_inc  (pc_inc),
		.pc_load (pc_load),
		.target  (target),
		.pc      (pc)
	);

	cpu_datapath u_cpu_datapath (
		.clk       (clk),
		.reset_n   (reset_n),
		.ctrl      (ctrl),
		.pc        (pc),
		.mem_rdata (mem_rdata),
		.instr     (instr),
		.cond_true (cond_true),
		.target    (target),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	// address and write data come from MAR and MDR so they hold through the request
	assign mem_req.req   = req_valid;
	assign mem_req.we    = req_we;
	assign mem_req.addr  = mem_addr;
	assign mem_req.wdata = mem_wdata;

endmodule

// ==== dv/cpu_properties.sv ====
`timescale 1ns/1ps
module cpu_properties (
	input logic clk,
	input logic reset_n,
	input logic req,
	input logic we,
	input logic ack,
	input logic halted
);

	// a request stays up until the memory answers
	req_held: assert property (@(posedge clk) disable iff (!reset_n)
		req && !ack |=> req)
		else $error("memory request dropped before ack");

	we_stable: assert property (@(posedge clk) disable iff (!reset_n)
		req && $past(req) |-> $stable(we))
		else $error("write enable changed during a request");

	no_early_req: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(req) |-> !ack)
		else $error("request raised while ack still high");

	halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		halted |=> halted)
		else $error("halted fell without reset");

endmodule

bind cpu_control cpu_properties props (
	.clk      (clk),
	.reset_n  (reset_n),
	.req      (mem_req_valid),
	.we       (mem_we),
	.ack      (mem_ack),
	.halted   (halted)
);

// ==== dv/cpu_checker.sv ====
`timescale 1ns/1ps
module cpu_checker import cpu_pkg::*; (
	input logic     clk,
	input logic     reset_n,
	input mem_req_t mem_req,
	input logic     halted
);

	logic [WORD_W-1:0] ref_mem [256];  // program image, copied in before each test
	logic [WORD_W-1:0] exp_addr [$];
	logic [WORD_W-1:0] exp_data [$];
	string             test_name;
	int                seen;
	int                errors;
	int                error_count;
	logic              req_d;
	logic [WORD_W-1:0] addr_d;
	logic              halt_seen;
	logic              active;

	initial begin
		active = 1'b0;
		error_count = 0;
		errors = 0;
		seen = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction set reference, yields the ordered list of stores
	////////////////////////////////////////////////////////////////////////////

	function automatic bit run_reference();
		logic [WORD_W-1:0] regs [16];
		logic [WORD_W-1:0] word;
		logic [WORD_W-1:0] imm;
		logic [WORD_W-1:0] base;
		logic [WORD_W-1:0] rav;
		logic [WORD_W-1:0] rbv;
		logic [WORD_W-1:0] rcv;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] pc;
		logic [4:0]        op;
		logic [3:0]        ra;
		logic [3:0]        rb;
		logic [3:0]        rc;
		logic [1:0]        c2;
		bit                done;
		bit                pass;
		int                steps;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		exp_addr.delete();
		exp_data.delete();
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 5000) begin
			word = ref_mem[pc[7:0]];
			pc = pc + 1;
			steps++;
			op = word[31:27];
			ra = word[26:23];
			rb = word[22:19];
			rc = word[18:15];
			c2 = word[20:19];
			imm = {{13{word[18]}}, word[18:0]};
			rav = regs[ra];
			rbv = regs[rb];
			rcv = regs[rc];
			base = (rb == 4'd0) ? '0 : rbv; // r0 as a base is zero
			addr = base + imm;
			case (op)
				5'b00000: regs[ra] = ref_mem[addr[7:0]];
				5'b00001: regs[ra] = addr;
				5'b00010: begin
					ref_mem[addr[7:0]] = rav;
					exp_addr.push_back(addr);
					exp_data.push_back(rav);
				end
				5'b00011: regs[ra] = rbv + rcv;
				5'b00100: regs[ra] = rbv - rcv;
				5'b00101: regs[ra] = rbv >> rcv[4:0];
				5'b00110: regs[ra] = rbv << rcv[4:0];
				5'b01001: regs[ra] = rbv & rcv;
				5'b01010: regs[ra] = rbv | rcv;
				5'b01100: regs[ra] = base & imm;
				5'b01101: regs[ra] = base | imm;
				5'b10000: regs[ra] = -rbv;
				5'b10001: regs[ra] = ~rbv;
				5'b10010: begin
					case (c2)
						2'd0: pass = (rav == 0);
						2'd1: pass = (rav != 0);
						2'd2: pass = !rav[31] && (rav != 0);
						default: pass = rav[31];
					endcase
					if (pass) pc = pc + imm; // pc already points past the branch
				end
				5'b11010: done = 1'b1;
				default: ;                    // nop and every undefined code
			endcase
		end
		return done;
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		errors = 0;
		seen = 0;
		if (!run_reference()) begin
			$display("test %s: reference model never reached halt", name);
			errors++;
		end
		active = 1'b1;
	endtask

	task automatic end_test(input int extra_errors, output int errs);
		errors += extra_errors;
		if (seen < exp_addr.size()) begin
			$display("test %s: %0d expected stores were never seen", test_name,
				exp_addr.size() - seen);
			errors++;
		end
		$display("test %-10s %0d of %0d stores  %s", test_name, seen, exp_addr.size(),
			(errors == 0) ? "pass" : "FAIL");
		error_count += errors;
		errs = errors;
		active = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare each observed write against the expected list
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!reset_n) begin
			req_d <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			req_d <= mem_req.req;
			addr_d <= mem_req.addr;
			if (halted) begin
				halt_seen <= 1'b1;
			end
			// any request once the processor has halted is activity past the program end
			if (active && halt_seen && mem_req.req) begin
				$display("test %s: memory request seen after halt", test_name);
				errors++;
			end
			// the address holds from the first request cycle until req drops
			if (active && mem_req.req && req_d && mem_req.addr !== addr_d) begin
				$display("test %s: address changed during a memory request", test_name);
				errors++;
			end
			if (active && mem_req.req && !req_d && mem_req.we) begin
				if (seen >= exp_addr.size()) begin
					$display("test %s: extra store to address %0d", test_name, mem_req.addr);
					errors++;
				end else if (mem_req.addr !== exp_addr[seen]) begin
					$display("ERROR test %s store %0d address: expected %h actual %h",
						test_name, seen, exp_addr[seen], mem_req.addr);
					errors++;
				end else if (mem_req.wdata !== exp_data[seen]) begin
					$display("ERROR test %s store %0d data: expected %h actual %h",
						test_name, seen, exp_data[seen], mem_req.wdata);
					errors++;
				end
				seen++;
			end
		end
	end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
module tb_top import cpu_pkg::*; ();

	logic              clk;
	logic              reset_n;
	logic              mem_ack;
	logic [WORD_W-1:0] mem_rdata;
	mem_req_t          mem_req;
	logic              halted;
	logic [WORD_W-1:0] mem [256];
	int                wait_cnt;
	int                load_ptr;
	int                tests_run;
	int                tests_failed;

	cpu_top dut (
		.clk       (clk),
		.reset_n   (reset_n),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.mem_req   (mem_req),
		.halted    (halted)
	);

	cpu_checker chk (
		.clk     (clk),
		.reset_n (reset_n),
		.mem_req (mem_req),
		.halted  (halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// memory model, answers after 0 to 3 idle cycles and drops ack with req
	always @(posedge clk) begin
		if (!reset_n) begin
			mem_ack <= 1'b0;
		end else if (mem_req.req && !mem_ack) begin
			if (wait_cnt == 0) begin
				mem_ack <= 1'b1;
				wait_cnt <= $urandom_range(3, 0);
				if (mem_req.we) begin
					mem[mem_req.addr[7:0]] = mem_req.wdata;
				end else begin
					mem_rdata <= mem[mem_req.addr[7:0]];
				end
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else if (!mem_req.req) begin
			mem_ack <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding and program building
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] reg_form(opcode_e op, int ra, int rb, int rc);
		return {op, ra[3:0], rb[3:0], rc[3:0], 15'b0};
	endfunction

	function automatic logic [31:0] imm_form(opcode_e op, int ra, int rb, int imm);
		return {op, ra[3:0], rb[3:0], imm[18:0]};
	endfunction

	function automatic logic [31:0] branch_form(int ra, int c2, int imm);
		return {OP_BR, ra[3:0], 2'b00, c2[1:0], imm[18:0]};
	endfunction

	task automatic clear_memory();
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0101);
		end
		load_ptr = 0;
	endtask

	task automatic put_word(input logic [31:0] word);
		mem[load_ptr] = word;
		load_ptr++;
	endtask

	task automatic store_reg(input int r, input int addr);
		put_word(imm_form(OP_ST, r, 0, addr));
	endtask

	task automatic alu_program();
		clear_memory();
		mem[200] = 32'hf0f0_1234;
		mem[201] = 32'h8000_0023;          // shift count 3 in the low bits
		put_word(imm_form(OP_LD, 1, 0, 200));
		put_word(imm_form(OP_LD, 2, 0, 201));
		put_word(reg_form(OP_ADD, 3, 1, 2));
		put_word(reg_form(OP_SUB, 4, 1, 2));
		put_word(reg_form(OP_AND, 5, 1, 2));
		put_word(reg_form(OP_OR, 6, 1, 2));
		put_word(reg_form(OP_SHR, 7, 1, 2));
		put_word(reg_form(OP_SHL, 8, 1, 2));
		put_word(reg_form(OP_SUB, 9, 2, 1));
		for (int r = 3; r <= 9; r++) begin
			store_reg(r, 217 + r);
		end
		put_word({OP_HALT, 27'b0});
	endtask

	task automatic immediate_program();
		clear_memory();
		put_word(imm_form(OP_LDI, 1, 0, -5));
		put_word(imm_form(OP_LDI, 2, 0, 100));
		put_word(imm_form(OP_LDI, 3, 2, 7));
		put_word(imm_form(OP_ANDI, 4, 1, 32'h0ff0));
		put_word(imm_form(OP_ANDI, 6, 1, -16));
		put_word(imm_form(OP_LDI, 0, 0, 55)); // r0 now holds 55 but reads zero as a base
		put_word(imm_form(OP_ORI, 5, 0, 3));
		put_word(imm_form(OP_ORI, 7, 2, -256));
		put_word(imm_form(OP_LDI, 8, 0, -1));
		for (int r = 0; r <= 8; r++) begin
			store_reg(r, 220 + r);
		end
		put_word({OP_HALT, 27'b0});
	endtask

	task automatic memory_program();
		clear_memory();
		mem[213] = 32'h0000_4d2f;
		put_word(imm_form(OP_LDI, 1, 0, 210));
		put_word(imm_form(OP_LD, 2, 1, 3));
		put_word(reg_form(OP_NEG, 3, 2, 0));
		put_word(reg_form(OP_NOT, 4, 2, 0));
		put_word(imm_form(OP_ST, 3, 1, 5));
		put_word(imm_form(OP_ST, 4, 1, -2));
		put_word(imm_form(OP_LD, 5, 1, 5));  // reads back the store above
		put_word(imm_form(OP_ST, 5, 1, 20));
		put_word({OP_HALT, 27'b0});
	endtask

	task automatic branch_program();
		int vals [3];
		vals = '{0, 5, -3};
		clear_memory();
		// each case skips its first store when the branch is taken
		for (int k = 0; k < 12; k++) begin
			put_word(imm_form(OP_LDI, 1, 0, vals[k / 4]));
			put_word(branch_form(1, k % 4, 1));
			store_reg(1, 200 + 2 * k);
			store_reg(1, 201 + 2 * k);
		end
		put_word({OP_HALT, 27'b0});
	endtask

	task automatic idle_program();
		clear_memory();
		put_word(imm_form(OP_LDI, 1, 0, 9));
		put_word({OP_NOP, 27'b0});
		put_word({5'b00111, 27'h123_4567});
		put_word({5'b11111, 27'h7ff_ffff});
		put_word({OP_NOP, 27'b0});
		store_reg(1, 230);
		store_reg(2, 231);
		store_reg(15, 232);
		put_word({OP_HALT, 27'b0});
	endtask

	task automatic random_program();
		int ra;
		int rb;
		int rc;
		int imm;
		clear_memory();
		for (int k = 0; k < 30; k++) begin
			ra = $urandom_range(15, 0);
			rb = $urandom_range(15, 0);
			rc = $urandom_range(15, 0);
			imm = $urandom_range(524287, 0);
			case ($urandom_range(11, 0))
				0: put_word(reg_form(OP_ADD, ra, rb, rc));
				1: put_word(reg_form(OP_SUB, ra, rb, rc));
				2: put_word(reg_form(OP_AND, ra, rb, rc));
				3: put_word(reg_form(OP_OR, ra, rb, rc));
				4: put_word(reg_form(OP_SHR, ra, rb, rc));
				5: put_word(reg_form(OP_SHL, ra, rb, rc));
				6: put_word(imm_form(OP_LDI, ra, rb, imm));
				7: put_word(imm_form(OP_ANDI, ra, rb, imm));
				8: put_word(imm_form(OP_ORI, ra, rb, imm));
				9: put_word(reg_form(OP_NEG, ra, rb, 0));
				10: put_word(reg_form(OP_NOT, ra, rb, 0));
				default: put_word(imm_form(OP_LD, ra, 0, 200 + rc));
			endcase
		end
		for (int r = 0; r < 16; r++) begin
			store_reg(r, 240 + r);
		end
		put_word({OP_HALT, 27'b0});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequencing
	////////////////////////////////////////////////////////////////////////////

	task automatic run_program(input string name, input bit watch_idle);
		int cycles;
		int errs;
		int idle_errors;
		cycles = 0;
		idle_errors = 0;
		for (int i = 0; i < 256; i++) begin
			chk.ref_mem[i] = mem[i];
		end
		chk.begin_test(name);
		@(posedge clk);
		reset_n <= 1'b0;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		while (!halted) begin
			@(posedge clk);
			cycles++;
			if (cycles > 20000) begin
				$display("test %s: processor did not halt within 20000 cycles", name);
				$display("Something failed");
				$finish;
			end
		end
		if (watch_idle) begin
			for (int c = 0; c < 100; c++) begin
				@(posedge clk);
				if (!halted) begin
					$display("test %s: halted dropped %0d cycles after halt", name, c);
					idle_errors++;
				end
			end
		end
		chk.end_test(idle_errors, errs);
		tests_run++;
		if (errs > 0) begin
			tests_failed++;
		end
	endtask

	initial begin
		void'($urandom(6));
		reset_n = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		wait_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		alu_program();
		run_program("alu", 1'b0);
		immediate_program();
		run_program("immediate", 1'b0);
		memory_program();
		run_program("memory", 1'b0);
		branch_program();
		run_program("branch", 1'b0);
		idle_program();
		run_program("idle", 1'b1);
		random_program();
		run_program("random", 1'b0);
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			chk.error_count);
		if (tests_failed == 0 && chk.error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/program_counter.sv
design/cpu_control.sv
design/cpu_datapath.sv
design/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_checker.sv
dv/tb_top.sv
